// File: cps2Decrypt.f
+incdir+.
cps2CryptPkg.sv
cps2KeyLoad.sv
cps2RangeCheck.sv
cps2FeistelRound.sv
cps2FeistelPipe.sv
cps2Decrypt.sv
tbCps2Decrypt.sv

// File: tbCps2Model.svh
// CPS2 decrypt testbench model
// board bit map, Feistel round rule and range test, plus drive and check tasks
`ifndef TB_CPS2_MODEL_SVH
`define TB_CPS2_MODEL_SVH

// one fetch waiting for its output word
typedef struct packed {
    wordAddrT    addr;   // address the word must come back with
    cryptWordT   data;   // expected output word
    logic [31:0] cycle;  // clock count at issue
} expectT;

expectT expQ[$];        // outstanding fetches, oldest first
rawCfgT modelRaw;       // what the loader should hold
int     modelCnt;       // bytes loaded since reset

// board wiring, built group by group from 16-bit source words
function automatic rawCfgT mapCfg(input rawCfgT r);
    rawCfgT      m;
    logic [15:0] s;       // source group
    logic [15:0] w;       // output group, msb first
    int          srcGrp;
    int          lo;      // first of the two borrowed bits
    m = '0;
    for (int g = 0; g < 10; g++) begin
        srcGrp = (g < 6) ? g : (g ^ 1);    // key groups swapped in pairs
        s      = r[16*srcGrp +: 16];
        lo     = (16*srcGrp + 152) % 160;  // one byte below, wraps to the top
        for (int k = 0; k < 6; k++) begin
            w[15-k] = s[10+k];             // bits 10..15, reversed
        end
        for (int k = 0; k < 8; k++) begin
            w[9-k] = s[k];                 // low byte, reversed
        end
        w[1] = r[lo];
        w[0] = r[lo+1];
        m[159-16*g -: 16] = w;
    end
    return m;
endfunction

// one round: L' = R, R' = L ^ (rotl(R ^ kLo ^ a, rot) + kHi)
function automatic cryptWordT roundModel(input cryptWordT w, input cryptWordT k,
                                         input halfT a, input int rot);
    halfT t;
    halfT f;
    t = w[7:0] ^ k[7:0] ^ a;
    t = (t << rot) | (t >> (8 - rot));
    f = t + k[15:8];                       // 8-bit wrap
    return {w[7:0], w[15:8] ^ f};
endfunction

function automatic cryptWordT feistelModel(input cryptWordT d, input keyT k,
                                           input wordAddrT a);
    cryptWordT w;
    w = d;
    for (int i = 0; i < NumRounds; i++) begin
        w = roundModel(w, k[16*i +: 16], a[7:0], i + 1);
    end
    return w;
endfunction

function automatic logic inRangeModel(input wordAddrT a, input rangeT rng);
    return a[22:7] <= rng;                 // block number against the limit
endfunction

function automatic cryptWordT expectedWord(input wordAddrT a, input cryptWordT d);
    rawCfgT m;
    m = mapCfg(modelRaw);
    if (modelCnt >= CfgBytes && inRangeModel(a, m[159:144])) begin
        return feistelModel(d, m[63:0], a);
    end
    return d;                              // no key yet or out of range
endfunction

task automatic checkEq(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        errCount++;
        $display("ERROR at %0t: %s, got %0h expected %0h", $time, what, got, exp);
    end
endtask

// one config byte, cfgWe optionally held for extra cycles
task automatic loadByte(input cfgByteT b, input int holdCycles);
    @(negedge clk);
    fetchValid = 1'b0;
    cfgByte    = b;
    cfgWe      = 1'b1;
    modelRaw   = {b, modelRaw[159:8]};     // new byte at the top
    if (modelCnt < CfgBytes) begin
        modelCnt++;
    end
    repeat (holdCycles) begin
        @(negedge clk);
        cfgByte = ~b;                      // must not be taken, level only
    end
    @(negedge clk);
    cfgWe = 1'b0;
endtask

task automatic loadRandomConfig();
    repeat (CfgBytes) begin
        loadByte(cfgByteT'($urandom), 0);
    end
endtask

task automatic issueFetch(input wordAddrT a, input cryptWordT d);
    expectT e;
    @(negedge clk);
    fetchValid = 1'b1;
    fetchAddr  = a;
    fetchData  = d;
    e.addr     = a;
    e.data     = expectedWord(a, d);
    e.cycle    = cycleCnt;
    expQ.push_back(e);
endtask

// stop fetching and wait until every word is back
task automatic waitDrain();
    int waited;
    waited = 0;
    @(negedge clk);
    fetchValid = 1'b0;
    while (expQ.size() != 0 && waited < DrainLimit) begin
        @(posedge clk);                    // queue only moves on negedges
        waited++;
    end
    if (expQ.size() != 0) begin
        errCount++;
        $display("%0d fetches never came out, time %0t", expQ.size(), $time);
        expQ.delete();
    end
    @(negedge clk);
endtask

`endif

// File: tbCps2Decrypt.sv
// CPS2 decrypt testbench
// directed tests of key loading, range check and Feistel pipe against a model
`timescale 1ns/1ps

module tbCps2Decrypt
    import cps2CryptPkg::*;
();

    localparam int NumRounds   = 4;
    localparam int Latency     = 1 + NumRounds;      // fetch to outValid
    localparam int ClkPeriod   = 8;
    localparam int LoadCycles  = 2 * CfgBytes + 1;   // rise and fall per byte
    localparam int DrainLimit  = 2 * Latency + 8;
    localparam int TestCycles  = 10
        + (8 + DrainLimit)                           // reset pass-through
        + (LoadCycles + 10 + DrainLimit)             // key loading
        + 3 * (LoadCycles + 12 + DrainLimit)         // decryption
        + (4 * LoadCycles + 6 + DrainLimit)          // range boundary
        + (24 + DrainLimit)                          // back to back
        + 2 * (LoadCycles + 10 + DrainLimit);        // reload
    localparam int WatchdogNs  = (2 * TestCycles + 200) * ClkPeriod;

    logic      clk;
    logic      rst;
    cfgByteT   cfgByte;
    logic      cfgWe;
    logic      fetchValid;
    wordAddrT  fetchAddr;
    cryptWordT fetchData;
    logic      outValid;
    wordAddrT  outAddr;
    cryptWordT outData;
    logic      keyReady;

    logic [31:0] cycleCnt = '0;   // rising edges seen
    int          errCount = 0;
    int          passCount = 0;
    int          failCount = 0;

    `include "tbCps2Model.svh"

    cps2Decrypt #(
        .NumRounds (NumRounds)
    ) u_cps2Decrypt (
        .clk        (clk),
        .rst        (rst),
        .cfgByte    (cfgByte),
        .cfgWe      (cfgWe),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .outValid   (outValid),
        .outAddr    (outAddr),
        .outData    (outData),
        .keyReady   (keyReady)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // output monitor sampled mid-cycle
    initial begin
        expectT e;
        forever begin
            @(negedge clk);
            if (outValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    errCount++;
                    $display("output word %0h at address %0h with no fetch outstanding, time %0t",
                             outData, outAddr, $time);
                end else begin
                    e = expQ.pop_front();
                    checkEq("output address", outAddr, e.addr);
                    checkEq("output data", outData, e.data);
                    checkEq("fetch latency", cycleCnt - e.cycle, Latency);
                end
            end
        end
    end

    function automatic rangeT currentRng();
        rawCfgT m;
        m = mapCfg(modelRaw);
        return m[159:144];
    endfunction

    // in-range address or one above the limit when there is room
    function automatic wordAddrT pickAddr(input logic wantIn);
        rangeT       rng;
        logic [15:0] blk;
        rng = currentRng();
        if (wantIn || rng == 16'hffff) begin
            blk = 16'($urandom % (32'(rng) + 32'd1));
        end else begin
            blk = rng + 16'd1 + 16'($urandom % (32'hffff - 32'(rng)));
        end
        return {blk, 7'($urandom)};
    endfunction

    task automatic finishTest(input string name, input int errsBefore);
        if (errCount == errsBefore) begin
            passCount++;
            $display("%s: pass", name);
        end else begin
            failCount++;
            $display("%s: fail, %0d errors", name, errCount - errsBefore);
        end
    endtask

    task automatic resetPassThrough();
        int errs;
        errs = errCount;
        checkEq("keyReady after reset", keyReady, 0);
        checkEq("outValid after reset", outValid, 0);
        repeat (4) begin
            issueFetch({16'h0000, 7'($urandom)}, cryptWordT'($urandom));  // under the zero limit
            issueFetch(wordAddrT'($urandom), cryptWordT'($urandom));
        end
        waitDrain();
        finishTest("reset and pre-key pass-through", errs);
    endtask

    task automatic keyLoading();
        int errs;
        errs = errCount;
        repeat (CfgBytes - 2) begin
            loadByte(cfgByteT'($urandom), 0);
        end
        checkEq("keyReady after 18 edges", keyReady, 0);
        loadByte(cfgByteT'($urandom), 5);   // held level takes one edge
        @(negedge clk);
        checkEq("keyReady after 19 edges", keyReady, 0);
        loadByte(cfgByteT'($urandom), 0);
        @(negedge clk);
        checkEq("keyReady after 20 edges", keyReady, 1);
        issueFetch({16'h0000, 7'($urandom)}, cryptWordT'($urandom));  // block 0 always in
        issueFetch(pickAddr(1'b1), cryptWordT'($urandom));
        waitDrain();
        finishTest("key loading", errs);
    endtask

    task automatic decryptRandomKeys();
        int errs;
        errs = errCount;
        repeat (3) begin
            loadRandomConfig();
            repeat (12) begin
                issueFetch(pickAddr(1'b1), cryptWordT'($urandom));
            end
            waitDrain();
        end
        finishTest("decryption", errs);
    endtask

    task automatic rangeBoundary();
        int    errs;
        int    tries;
        rangeT rng;
        errs  = errCount;
        tries = 0;
        loadRandomConfig();
        rng = currentRng();
        while ((rng == 16'h0000 || rng == 16'hffff) && tries < 3) begin
            loadRandomConfig();   // need room on both sides of the limit
            rng = currentRng();
            tries++;
        end
        issueFetch({rng, 7'h7f}, cryptWordT'($urandom));            // last word in
        issueFetch({rng, 7'h00}, cryptWordT'($urandom));
        issueFetch({rng - 16'd1, 7'($urandom)}, cryptWordT'($urandom));
        issueFetch({rng + 16'd1, 7'h00}, cryptWordT'($urandom));    // first word out
        issueFetch({rng + 16'd1, 7'($urandom)}, cryptWordT'($urandom));
        waitDrain();
        finishTest("range boundary", errs);
    endtask

    task automatic backToBackFetches();
        int errs;
        errs = errCount;
        repeat (24) begin
            issueFetch(pickAddr(1'($urandom)), cryptWordT'($urandom));  // one per cycle
        end
        waitDrain();
        finishTest("back-to-back fetches", errs);
    endtask

    task automatic configReload();
        int errs;
        errs = errCount;
        loadRandomConfig();
        repeat (6) begin
            issueFetch(pickAddr(1'($urandom)), cryptWordT'($urandom));
        end
        waitDrain();
        repeat (CfgBytes) begin
            loadByte(cfgByteT'($urandom), 0);
            checkEq("keyReady during reload", keyReady, 1);
        end
        repeat (10) begin
            issueFetch(pickAddr(1'($urandom)), cryptWordT'($urandom));
        end
        waitDrain();
        finishTest("reload", errs);
    endtask

    initial begin
        void'($urandom(32'hfda3_c4e2));
        rst        = 1'b1;
        cfgByte    = '0;
        cfgWe      = 1'b0;
        fetchValid = 1'b0;
        fetchAddr  = '0;
        fetchData  = '0;
        modelRaw   = '0;
        modelCnt   = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        resetPassThrough();
        keyLoading();
        decryptRandomKeys();
        rangeBoundary();
        backToBackFetches();
        configReload();
        $display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errCount);
        if (failCount == 0 && errCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WatchdogNs);
        $display("run timed out after %0d ns, tests did not finish", WatchdogNs);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: cps2Decrypt.sv
// CPS2 program decryption top
// config loader, range check and Feistel pipe, fetch to output in
// 1 + NumRounds cycles
`timescale 1ns/1ps

module cps2Decrypt
    import cps2CryptPkg::*;
#(
    parameter int NumRounds = 4      // pipe depth, 1..4
) (
    input  logic      clk,
    input  logic      rst,

    // config stream
    input  cfgByteT   cfgByte,
    input  logic      cfgWe,         // byte taken on each rising edge

    // opcode fetch, one per cycle at most
    input  logic      fetchValid,
    input  wordAddrT  fetchAddr,
    input  cryptWordT fetchData,

    // decrypted word, single cycle pulse, no back-pressure
    output logic      outValid,
    output wordAddrT  outAddr,
    output cryptWordT outData,
    output logic      keyReady
);

    keyT   key;        // mapped key
    rangeT addrRng;    // mapped range limit
    fetchT rangeOut;   // registered fetch with crypt flag
    fetchT pipeOut;    // after the last round

    cps2KeyLoad u_keyLoad (
        .clk      (clk),
        .rst      (rst),
        .cfgByte  (cfgByte),
        .cfgWe    (cfgWe),
        .key      (key),
        .addrRng  (addrRng),
        .keyReady (keyReady)
    );

    cps2RangeCheck u_rangeCheck (
        .clk        (clk),
        .rst        (rst),
        .fetchValid (fetchValid),
        .fetchAddr  (fetchAddr),
        .fetchData  (fetchData),
        .addrRng    (addrRng),
        .keyReady   (keyReady),
        .stageOut   (rangeOut)
    );

    cps2FeistelPipe #(
        .NumRounds (NumRounds)
    ) u_feistelPipe (
        .clk      (clk),
        .rst      (rst),
        .stageIn  (rangeOut),
        .key      (key),
        .stageOut (pipeOut)
    );

    // unpack the last stage
    assign outValid = pipeOut.valid;
    assign outAddr  = pipeOut.addr;
    assign outData  = pipeOut.data;

endmodule

// File: cps2FeistelPipe.sv
// CPS2 Feistel pipeline
// chains the round stages, one cycle each, and hands every stage its
// 16-bit slice of the key
`timescale 1ns/1ps

module cps2FeistelPipe
    import cps2CryptPkg::*;
#(
    parameter int NumRounds = 4    // 1..4, one key slice per round
) (
    input  logic  clk,
    input  logic  rst,
    input  fetchT stageIn,         // from the range check
    input  keyT   key,             // used live by every stage
    output fetchT stageOut         // after the last round
);

    localparam int SliceW = $bits(cryptWordT);

    fetchT     chain [NumRounds+1];  // stage boundaries, 0 is the input
    cryptWordT roundKey [NumRounds];  // per round key slices

    assign chain[0] = stageIn;

    genvar i;
    generate
        for (i = 0; i < NumRounds; i++) begin : gRound
            // round i takes key bits 16i+15 down to 16i
            assign roundKey[i] = key[SliceW * i +: SliceW];

            cps2FeistelRound #(
                .RoundIdx (i)
            ) u_round (
                .clk      (clk),
                .rst      (rst),
                .stageIn  (chain[i]),
                .roundKey (roundKey[i]),
                .stageOut (chain[i+1])
            );
        end
    endgenerate

    assign stageOut = chain[NumRounds];  // crypt flag still set for decrypted words

endmodule

// File: cps2FeistelRound.sv
// CPS2 Feistel round stage
// one keyed round over the two opcode bytes, registered, with a plain
// pass-through for words outside the encrypted range
`timescale 1ns/1ps

module cps2FeistelRound
    import cps2CryptPkg::*;
#(
    parameter int RoundIdx = 0     // round number, sets the rotate amount
) (
    input  logic      clk,
    input  logic      rst,
    input  fetchT     stageIn,     // from the previous stage
    input  cryptWordT roundKey,    // this round's key slice
    output fetchT     stageOut
);

    localparam int Rot = (RoundIdx + 1) % 8;  // left rotate of the mixed byte

    halfT      lHalf;      // data[15:8]
    halfT      rHalf;      // data[7:0]
    halfT      mixVal;     // r ^ key low ^ addr low
    halfT      rotVal;
    halfT      fOut;       // round function result
    cryptWordT roundData;  // swapped halves after the round
    cryptWordT dataNxt;
    logic      validQ;
    logic      cryptQ;
    wordAddrT  addrQ;
    cryptWordT dataQ;

    assign lHalf = stageIn.data[15:8];
    assign rHalf = stageIn.data[7:0];

    // round function, address tweak keeps equal words at different addrs apart
    assign mixVal = rHalf ^ roundKey[7:0] ^ stageIn.addr[7:0];
    assign rotVal = halfT'({mixVal, mixVal} >> (8 - Rot));
    assign fOut   = rotVal + roundKey[15:8];  // wraps mod 256

    // new l = r, new r = l ^ f
    assign roundData = {rHalf, lHalf ^ fOut};
    assign dataNxt   = stageIn.crypt ? roundData : stageIn.data;

    // control bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
            cryptQ <= 1'b0;
        end else begin
            validQ <= stageIn.valid;
            cryptQ <= stageIn.crypt;
        end
    end

    // payload, address travels with the word
    always_ff @(posedge clk) begin
        addrQ <= stageIn.addr;
        dataQ <= dataNxt;
    end

    assign stageOut.addr  = addrQ;
    assign stageOut.data  = dataQ;
    assign stageOut.crypt = cryptQ;
    assign stageOut.valid = validQ;

endmodule

// File: cps2RangeCheck.sv
// CPS2 fetch range check
// registers each opcode fetch and flags it for decryption when it falls
// inside the keyed address range
`timescale 1ns/1ps

module cps2RangeCheck
    import cps2CryptPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      fetchValid,  // one cycle fetch strobe
    input  wordAddrT  fetchAddr,
    input  cryptWordT fetchData,   // word as read from rom
    input  rangeT     addrRng,     // from the key loader
    input  logic      keyReady,    // no decryption before a full config
    output fetchT     stageOut     // first pipe stage
);

    localparam int AddrW = $bits(wordAddrT);
    localparam int RngW  = $bits(rangeT);

    logic      inRange;   // addr block at or below the limit
    logic      cryptNxt;
    logic      validQ;
    logic      cryptQ;
    wordAddrT  addrQ;
    cryptWordT dataQ;

    // compare addr[22:7], the 128-word block number
    assign inRange  = (fetchAddr[AddrW-1 -: RngW] <= addrRng);
    assign cryptNxt = keyReady & fetchValid & inRange;

    // control bits
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            validQ <= 1'b0;
            cryptQ <= 1'b0;
        end else begin
            validQ <= fetchValid;
            cryptQ <= cryptNxt;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        addrQ <= fetchAddr;
        dataQ <= fetchData;
    end

    assign stageOut.addr  = addrQ;
    assign stageOut.data  = dataQ;
    assign stageOut.crypt = cryptQ;
    assign stageOut.valid = validQ;

endmodule

// File: cps2KeyLoad.sv
// CPS2 key loader
// shifts the 20-byte config stream into a raw register and maps it
// onto the 64-bit key and the 16-bit range limit
`timescale 1ns/1ps

module cps2KeyLoad
    import cps2CryptPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  cfgByteT cfgByte,   // config byte from the host
    input  logic    cfgWe,     // write level, one byte per rising edge
    output keyT     key,       // round keys, 16 bits each
    output rangeT   addrRng,   // last encrypted addr[22:7] block
    output logic    keyReady   // full config seen since reset
);

    localparam int CfgBits   = $bits(rawCfgT);
    localparam int GrpBits   = 16;
    localparam int NumGroups = CfgBits / GrpBits;
    localparam int CntW      = $clog2(CfgBytes + 1);

    logic            cfgWeLast;  // previous cfgWe sample
    logic            cfgEdge;    // rising edge of cfgWe
    rawCfgT          raw;        // bytes as shifted in
    rawCfgT          cfgMap;     // raw after the board bit map
    logic [CntW-1:0] byteCnt;    // captured bytes, saturating

    // raw bit that feeds position pos (0 = msb) of output group grp
    function automatic int srcBit(input int grp, input int pos);
        int base;
        int idx;
        // top six groups in order, the key words swapped in pairs
        base = GrpBits * ((grp < 6) ? grp : (grp ^ 1));
        if (pos < 6) begin
            idx = base + 10 + pos;   // bits 10..15 of the source group
        end else if (pos < 14) begin
            idx = base + pos - 6;    // low byte of the source group
        end else begin
            idx = base + pos - 22;   // two bits from the group below
        end
        if (idx < 0) begin
            idx = idx + CfgBits;     // group 0 borrows from the top of raw
        end
        return idx;
    endfunction

    assign cfgEdge = cfgWe & ~cfgWeLast;

    // strobe edge detect and shift register
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfgWeLast <= 1'b0;
            raw       <= '0;
        end else begin
            cfgWeLast <= cfgWe;
            if (cfgEdge) begin
                raw <= {cfgByte, raw[CfgBits-1:8]};  // new byte enters at the top
            end
        end
    end

    // byte counter, stops once a full config has been seen
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byteCnt <= '0;
        end else if (cfgEdge && (byteCnt != CntW'(CfgBytes))) begin
            byteCnt <= byteCnt + CntW'(1);
        end
    end

    // holds until reset since the counter saturates
    assign keyReady = (byteCnt == CntW'(CfgBytes));

    // fixed board wiring, 16-bit groups with a two byte rotation
    always_comb begin
        cfgMap = '0;
        for (int g = 0; g < NumGroups; g++) begin
            for (int b = 0; b < GrpBits; b++) begin
                cfgMap[CfgBits - 1 - GrpBits * g - b] = raw[srcBit(g, b)];
            end
        end
    end

    // later reloads keep shifting, so the key tracks raw
    assign key     = cfgMap[$bits(keyT)-1:0];
    assign addrRng = cfgMap[CfgBits-1 -: $bits(rangeT)];  // top group

endmodule

// File: cps2CryptPkg.sv
// CPS2 program decryption shared types
// widths of words, addresses and key material, plus the record that walks the pipe

package cps2CryptPkg;

    // opcode path
    typedef logic [15:0]  cryptWordT;  // one 68000 opcode word
    typedef logic [7:0]   halfT;       // feistel half word
    typedef logic [22:0]  wordAddrT;   // cpu word address, a23..a1

    // key material
    typedef logic [63:0]  keyT;        // four 16-bit round keys
    typedef logic [15:0]  rangeT;      // upper limit on addr[22:7]
    typedef logic [159:0] rawCfgT;     // loaded config before the bit map
    typedef logic [7:0]   cfgByteT;    // one config byte from the host

    localparam int CfgBytes = 20;      // bytes per full config load

    // one fetch in flight
    typedef struct packed {
        wordAddrT  addr;   // word address of the fetch
        cryptWordT data;   // opcode word, cipher or plain
        logic      crypt;  // word lies in the encrypted range
        logic      valid;  // slot holds a fetch
    } fetchT;

endpackage
